// File: design/core_av_pkg.sv
package core_av_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // shared types
    ////////////////////////////////////////////////////////////////////////////

    // horizontal or vertical counter value
    typedef logic [9:0] coord_t;

    // rgb, red in the high byte
    typedef logic [23:0] pixel_t;

    ////////////////////////////////////////////////////////////////////////////
    // video geometry at ~12.288 MHz pixel rate
    ////////////////////////////////////////////////////////////////////////////

    // line geometry in clocks
    localparam int H_TOTAL   = 400;
    localparam int H_ACTIVE  = 320;
    localparam int H_BPORCH  = 10;
    // frame geometry in lines
    localparam int V_TOTAL   = 512;
    localparam int V_ACTIVE  = 240;
    localparam int V_BPORCH  = 10;
    // hs fires a few clocks into the line, clear of vs
    localparam int HS_OFFSET = 3;

    localparam pixel_t ACTIVE_COLOR = 24'hff_00_00;
    localparam pixel_t BLANK_COLOR  = 24'h00_00_00;

    ////////////////////////////////////////////////////////////////////////////
    // i2s framing
    ////////////////////////////////////////////////////////////////////////////

    // mclk cycles per sclk period
    localparam int SCLK_DIV  = 4;
    // sclk periods per lrck half
    localparam int SLOT_BITS = 32;

endpackage

// File: design/vid_sync_if.sv
interface vid_sync_if;

    import core_av_pkg::*;

    // timing flags, one cycle pulses and a level
    logic   de;
    logic   hs;
    logic   vs;
    // visible coordinates, valid with de
    coord_t x;
    coord_t y;

    // timing generator side
    modport src (
        output de, hs, vs, x, y
    );

    // pixel stage side
    modport dst (
        input de, hs, vs, x, y
    );

endinterface

// File: design/video_timing.sv
module video_timing #(
    parameter int h_total   = core_av_pkg::H_TOTAL,
    parameter int h_active  = core_av_pkg::H_ACTIVE,
    parameter int h_bporch  = core_av_pkg::H_BPORCH,
    parameter int hs_offset = core_av_pkg::HS_OFFSET,
    parameter int v_total   = core_av_pkg::V_TOTAL,
    parameter int v_active  = core_av_pkg::V_ACTIVE,
    parameter int v_bporch  = core_av_pkg::V_BPORCH
) (
    input  logic       audgen_mclk,
    input  logic       reset_n,
    vid_sync_if.src    sync
);

    import core_av_pkg::*;

    // counter limits and window edges
    localparam coord_t H_LAST  = coord_t'(h_total - 1);
    localparam coord_t V_LAST  = coord_t'(v_total - 1);
    localparam coord_t H_FIRST = coord_t'(h_bporch);
    localparam coord_t H_END   = coord_t'(h_bporch + h_active);
    localparam coord_t V_FIRST = coord_t'(v_bporch);
    localparam coord_t V_END   = coord_t'(v_bporch + v_active);
    localparam coord_t HS_AT   = coord_t'(hs_offset);

    coord_t x_count;
    coord_t y_count;
    logic   in_window;

    ////////////////////////////////////////////////////////////////////////////
    // raster counters
    ////////////////////////////////////////////////////////////////////////////

    // x wraps at end of line and steps y
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            x_count <= '0;
            y_count <= '0;
        end else begin
            if (x_count == H_LAST) begin
                x_count <= '0;
                // frame wrap
                if (y_count == V_LAST) begin
                    y_count <= '0;
                end else begin
                    y_count <= y_count + 1'b1;
                end
            end else begin
                x_count <= x_count + 1'b1;
            end
        end
    end

    // active region, both axes past the back porch
    assign in_window = (x_count >= H_FIRST) && (x_count < H_END)
                    && (y_count >= V_FIRST) && (y_count < V_END);

    ////////////////////////////////////////////////////////////////////////////
    // sync and enable, one cycle behind the counters
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            sync.vs <= 1'b0;
            sync.hs <= 1'b0;
            sync.de <= 1'b0;
        end else begin
            // new frame on the origin
            sync.vs <= (x_count == '0) && (y_count == '0);
            // new line, offset from vs
            sync.hs <= (x_count == HS_AT);
            sync.de <= in_window;
        end
    end

    // coordinates relative to porch, only meaningful with de
    always_ff @(posedge audgen_mclk) begin
        sync.x <= x_count - H_FIRST;
        sync.y <= y_count - V_FIRST;
    end

    // x must never reach the line length
    a_x_in_range: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        x_count < coord_t'(h_total));

    // hs sits in the back porch, never inside the window
    a_no_de_on_hs: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        !(sync.de && sync.hs));

endmodule

// File: design/video_pixel_out.sv
module video_pixel_out (
    input  logic                 audgen_mclk,
    input  logic                 reset_n,
    vid_sync_if.dst              sync,
    output core_av_pkg::pixel_t  video_rgb,
    output logic                 video_de,
    output logic                 video_hs,
    output logic                 video_vs
);

    import core_av_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // output stage
    ////////////////////////////////////////////////////////////////////////////

    // colour picked from the same de it leaves with
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            video_rgb <= BLANK_COLOR;
            video_de  <= 1'b0;
            video_hs  <= 1'b0;
            video_vs  <= 1'b0;
        end else begin
            // red test pattern inside the window
            video_rgb <= sync.de ? ACTIVE_COLOR : BLANK_COLOR;
            video_de  <= sync.de;
            // syncs delayed to stay aligned with colour
            video_hs  <= sync.hs;
            video_vs  <= sync.vs;
        end
    end

    // blanking outside the window
    a_blank_when_idle: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        !video_de |-> (video_rgb == BLANK_COLOR));

    // enable from the timing side must land on a visible coordinate
    a_de_in_window: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        sync.de |-> (sync.x < coord_t'(H_ACTIVE)) && (sync.y < coord_t'(V_ACTIVE)));

endmodule

// File: design/i2s_silence_tx.sv
module i2s_silence_tx #(
    parameter int sclk_div  = core_av_pkg::SCLK_DIV,
    parameter int slot_bits = core_av_pkg::SLOT_BITS
) (
    input  logic audgen_mclk,
    input  logic reset_n,
    output logic audio_sclk,
    output logic audio_lrck,
    output logic audio_dac
);

    localparam int PH_W   = $clog2(sclk_div);
    localparam int SLOT_W = $clog2(slot_bits);

    logic [PH_W-1:0]      phase;
    logic                 fall_en;
    logic [SLOT_W-1:0]    slot_cnt;

    ////////////////////////////////////////////////////////////////////////////
    // bit clock from the master clock, no derived clock domain
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    // msb of the phase register, 2 low then 2 high
    assign audio_sclk = phase[PH_W-1];
    // sclk drops on the next edge when phase wraps
    assign fall_en = (phase == PH_W'(sclk_div - 1));

    ////////////////////////////////////////////////////////////////////////////
    // word select and serial data, all on sclk falling edges
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            slot_cnt   <= '0;
            audio_lrck <= 1'b0;
            audio_dac  <= 1'b0;
        end else if (fall_en) begin
            slot_cnt <= slot_cnt + 1'b1;
            // silent sample, data line held low
            audio_dac <= 1'b0;
            if (slot_cnt == SLOT_W'(slot_bits - 1)) begin
                // switch channel
                audio_lrck <= ~audio_lrck;
            end
        end
    end

    // lrck only moves together with an sclk falling edge
    a_lrck_on_fall: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        $changed(audio_lrck) |-> $past(fall_en));

endmodule

// File: design/core_av_top.sv
module core_av_top (
    input  logic                 audgen_mclk,
    input  logic                 reset_n,

    // video to scaler
    output core_av_pkg::pixel_t  video_rgb,
    output logic                 video_de,
    output logic                 video_hs,
    output logic                 video_vs,

    // i2s to dac
    output logic                 audio_sclk,
    output logic                 audio_lrck,
    output logic                 audio_dac
);

    import core_av_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // video path, timing then pixel stage
    ////////////////////////////////////////////////////////////////////////////

    vid_sync_if vid_sync ();

    // 400 x 512 raster, 320 x 240 visible
    video_timing #(
        .h_total   (H_TOTAL),
        .h_active  (H_ACTIVE),
        .h_bporch  (H_BPORCH),
        .hs_offset (HS_OFFSET),
        .v_total   (V_TOTAL),
        .v_active  (V_ACTIVE),
        .v_bporch  (V_BPORCH)
    ) u_video_timing (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .sync        (vid_sync.src)
    );

    video_pixel_out u_video_pixel_out (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .sync        (vid_sync.dst),
        .video_rgb   (video_rgb),
        .video_de    (video_de),
        .video_hs    (video_hs),
        .video_vs    (video_vs)
    );

    ////////////////////////////////////////////////////////////////////////////
    // audio path, silent i2s
    ////////////////////////////////////////////////////////////////////////////

    i2s_silence_tx #(
        .sclk_div  (SCLK_DIV),
        .slot_bits (SLOT_BITS)
    ) u_i2s_silence_tx (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .audio_sclk  (audio_sclk),
        .audio_lrck  (audio_lrck),
        .audio_dac   (audio_dac)
    );

endmodule

// File: verification/tb_clk_rst.sv
module tb_clk_rst #(
    parameter int clk_period   = 8,
    parameter int reset_cycles = 5
) (
    output logic audgen_mclk,
    output logic reset_n
);

    timeunit 1ns;
    timeprecision 100ps;

    // free running master clock
    initial begin
        audgen_mclk = 1'b0;
        forever #(clk_period / 2) audgen_mclk = ~audgen_mclk;
    end

    // power-on reset, released on a rising edge
    initial begin
        reset_n = 1'b0;
        repeat (reset_cycles) @(posedge audgen_mclk);
        reset_n <= 1'b1;
    end

endmodule

// File: verification/tb_core_av_top.sv
module tb_core_av_top;

    timeunit 1ns;
    timeprecision 100ps;

    import core_av_pkg::*;

    localparam int RAND_SEED     = 93688;
    // counter stage plus pixel stage
    localparam int VIDEO_LATENCY = 2;
    localparam int MID_RST_LEN   = 4;
    localparam int POR_TIMEOUT   = 100;
    localparam int FRAME_LIMIT   = 3 * H_TOTAL * V_TOTAL + 1000;

    logic audgen_mclk, por_n, mid_rst_n, reset_n;
    pixel_t video_rgb;
    logic video_de, video_hs, video_vs;
    logic audio_sclk, audio_lrck, audio_dac;

    int check_count = 0;
    int error_count = 0;
    // monitor state, cycles counted from reset release
    int since_rel = -1;
    int vs_count = 0;
    int last_vs, last_hs, hs_in_frame, de_run, de_lines;
    int sclk_run, last_fall, last_lrck;
    bit hs_seen, fall_seen;
    logic prev_vs, prev_hs, prev_de, prev_sclk, prev_lrck;
    int unsigned reset_at;
    bit ok;

    tb_clk_rst #(.clk_period(8), .reset_cycles(5)) u_clk_rst (
        .audgen_mclk (audgen_mclk),
        .reset_n     (por_n)
    );

    // power-on reset or the mid-run reset
    assign reset_n = por_n & mid_rst_n;

    core_av_top i_dut (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .video_rgb   (video_rgb),
        .video_de    (video_de),
        .video_hs    (video_hs),
        .video_vs    (video_vs),
        .audio_sclk  (audio_sclk),
        .audio_lrck  (audio_lrck),
        .audio_dac   (audio_dac)
    );

    ////////////////////////////////////////////////////////////////////////////
    // reference model and compare
    ////////////////////////////////////////////////////////////////////////////

    function automatic pixel_t expected_rgb(input logic de);
        return de ? ACTIVE_COLOR : BLANK_COLOR;
    endfunction

    function automatic int expected_de_count();
        return H_ACTIVE;
    endfunction

    function automatic int expected_frame_cycles();
        return H_TOTAL * V_TOTAL;
    endfunction

    // one lrck half is a full slot of bit clocks
    function automatic int expected_lrck_period();
        return SCLK_DIV * SLOT_BITS;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t ns: %s is %0d (0x%0h), expected %0d (0x%0h)",
                     $time, name, actual, actual, expected, expected);
        end
    endtask

    task automatic clear_tracking();
        since_rel   = -1;
        vs_count    = 0;
        last_vs     = 0;
        last_hs     = 0;
        hs_in_frame = 0;
        hs_seen     = 1'b0;
        de_run      = 0;
        de_lines    = 0;
        sclk_run    = 0;
        last_fall   = 0;
        fall_seen   = 1'b0;
        // first lrck toggle is timed from release
        last_lrck   = 0;
        {prev_vs, prev_hs, prev_de, prev_sclk, prev_lrck} = '0;
    endtask

    // sampled on the falling edge, away from the rising-edge updates
    always @(negedge audgen_mclk) begin
        if (!reset_n) begin
            // every output held low in reset
            check_value("video_rgb", video_rgb, BLANK_COLOR);
            check_value("video_de", video_de, 1'b0);
            check_value("video_hs", video_hs, 1'b0);
            check_value("video_vs", video_vs, 1'b0);
            check_value("audio_sclk", audio_sclk, 1'b0);
            check_value("audio_lrck", audio_lrck, 1'b0);
            check_value("audio_dac", audio_dac, 1'b0);
            clear_tracking();
        end else begin
            since_rel = since_rel + 1;
            check_value("video_rgb", video_rgb, expected_rgb(video_de));
            check_value("audio_dac", audio_dac, 1'b0);
            // single cycle sync pulses
            if (prev_vs) begin
                check_value("video_vs", video_vs, 1'b0);
            end
            if (prev_hs) begin
                check_value("video_hs", video_hs, 1'b0);
            end
            if (video_hs) begin
                check_value("video_de_at_hs", video_de, 1'b0);
            end
            // frame start
            if (video_vs && !prev_vs) begin
                if (vs_count == 0) begin
                    check_value("vs_after_release", since_rel, VIDEO_LATENCY);
                end else begin
                    check_value("vs_period", since_rel - last_vs, expected_frame_cycles());
                    check_value("hs_per_frame", hs_in_frame, V_TOTAL);
                    check_value("de_lines_per_frame", de_lines, V_ACTIVE);
                end
                vs_count++;
                last_vs     = since_rel;
                hs_in_frame = 0;
                de_lines    = 0;
            end
            // line start
            if (video_hs && !prev_hs) begin
                if (hs_in_frame == 0 && vs_count > 0) begin
                    check_value("hs_after_vs", since_rel - last_vs, HS_OFFSET);
                end
                if (hs_seen) begin
                    check_value("hs_period", since_rel - last_hs, H_TOTAL);
                end
                hs_seen = 1'b1;
                last_hs = since_rel;
                hs_in_frame++;
            end
            // active window
            if (video_de && !prev_de) begin
                check_value("de_after_hs", since_rel - last_hs, H_BPORCH - HS_OFFSET);
            end
            if (video_de) begin
                de_run++;
            end else if (prev_de) begin
                check_value("de_length", de_run, expected_de_count());
                de_lines++;
                de_run = 0;
            end
            // bit clock halves and period
            if (audio_sclk != prev_sclk) begin
                check_value("sclk_half_period", sclk_run, SCLK_DIV / 2);
                sclk_run = 1;
            end else begin
                sclk_run++;
                // a stuck bit clock overruns its half period
                if (sclk_run > SCLK_DIV / 2) begin
                    check_value("sclk_half_period", sclk_run, SCLK_DIV / 2);
                end
            end
            if (prev_sclk && !audio_sclk) begin
                if (fall_seen) begin
                    check_value("sclk_period", since_rel - last_fall, SCLK_DIV);
                end
                fall_seen = 1'b1;
                last_fall = since_rel;
            end
            // word select, only on an sclk fall
            if (audio_lrck != prev_lrck) begin
                check_value("lrck_period", since_rel - last_lrck, expected_lrck_period());
                check_value("sclk_at_lrck", {prev_sclk, audio_sclk}, 2'b10);
                last_lrck = since_rel;
            end else if (since_rel - last_lrck > expected_lrck_period()) begin
                // word select overdue
                check_value("lrck_period", since_rel - last_lrck, expected_lrck_period());
            end
            prev_vs   = video_vs;
            prev_hs   = video_hs;
            prev_de   = video_de;
            prev_sclk = audio_sclk;
            prev_lrck = audio_lrck;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // run control
    ////////////////////////////////////////////////////////////////////////////

    task automatic wait_release(input int limit, output bit done);
        int cycles;
        cycles = 0;
        while (!reset_n && cycles < limit) begin
            @(posedge audgen_mclk);
            cycles++;
        end
        done = reset_n;
        if (!done) begin
            error_count++;
            $display("timeout: reset was not released within %0d cycles", limit);
        end
    endtask

    task automatic wait_frames(input int pulses, input int limit, output bit done);
        int cycles;
        cycles = 0;
        while (vs_count < pulses && cycles < limit) begin
            @(posedge audgen_mclk);
            cycles++;
        end
        done = (vs_count >= pulses);
        if (!done) begin
            error_count++;
            $display("timeout: saw only %0d of %0d vertical sync pulses", vs_count, pulses);
        end
    endtask

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    initial begin
        mid_rst_n = 1'b1;
        void'($urandom(RAND_SEED));
        // mid-run reset somewhere inside the first frame
        reset_at  = 1000 + ($urandom % 150000);
        wait_release(POR_TIMEOUT, ok);
        if (ok) begin
            repeat (reset_at) @(posedge audgen_mclk);
            mid_rst_n <= 1'b0;
            repeat (MID_RST_LEN) @(posedge audgen_mclk);
            mid_rst_n <= 1'b1;
            // three vs pulses bound two complete frames
            wait_frames(3, FRAME_LIMIT, ok);
        end
        finish_run();
    end

endmodule

// File: build.f
design/core_av_pkg.sv
design/vid_sync_if.sv
design/video_timing.sv
design/video_pixel_out.sv
design/i2s_silence_tx.sv
design/core_av_top.sv
verification/tb_clk_rst.sv
verification/tb_core_av_top.sv

// File: Bender.yml
package:
  name: core_av

sources:
  - design/core_av_pkg.sv
  - design/vid_sync_if.sv
  - design/video_timing.sv
  - design/video_pixel_out.sv
  - design/i2s_silence_tx.sv
  - design/core_av_top.sv
  - target: test
    files:
      - verification/tb_clk_rst.sv
      - verification/tb_core_av_top.sv
